// File: hw/cdc_bridge_cfg.svh
// CDC register bridge configuration
// Widths of the register address and data word, bank depth
// and the default handshake protocol of the crossing
`ifndef CDC_BRIDGE_CFG_SVH
`define CDC_BRIDGE_CFG_SVH

// Register address width, gives the bank depth
`define CDC_ADDR_W 4
// Register and Wishbone data width
`define CDC_DATA_W 32
// Number of registers in the destination bank
`define CDC_NUM_REGS (1 << `CDC_ADDR_W)
// Default protocol, 0 selects two-phase NRZ, 1 selects four-phase RZ
`define CDC_EN_RZ_HS 1'b0

`endif

// File: hw/cdc_bridge_pkg.sv
// CDC register bridge types
// Address and data words of the bridge and the one-bit phase
// state shared by both synchronizer FSMs
`default_nettype none

`include "cdc_bridge_cfg.svh"

package cdc_bridge_pkg;

  // Register index inside the bank
  typedef logic [`CDC_ADDR_W-1:0] addr_t;

  // Register contents and bus data
  typedef logic [`CDC_DATA_W-1:0] data_t;

  // Synchronizer FSM phase
  // NRZ reads this as even/odd, RZ as low/high
  typedef enum logic {
    PH_EVEN_LO = 1'b0,
    PH_ODD_HI  = 1'b1
  } sync_phase_e;

endpackage

`default_nettype wire

// File: hw/sync_2flop.sv
// Two-flop level synchronizer
// Brings a single bit into the receiving clock domain through
// two resettable flops in series
`timescale 1ns/1ps
`default_nettype none

module sync_2flop (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic d_i,
  output logic q_o
);

  // First stage, may go metastable
  logic meta_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= 1'b0;
      q_o    <= 1'b0;
    end else begin
      meta_q <= d_i;
      // Second stage settles the level
      q_o    <= meta_q;
    end
  end

endmodule

`default_nettype wire

// File: hw/sync_reqack.sv
// REQ/ACK handshake synchronizer
// Carries a request from the source to the destination domain
// and the acknowledge back, with one-cycle handshakes on both sides
// EN_RZ_HS = 0 gives the two-phase NRZ protocol, 1 the four-phase RZ
`timescale 1ns/1ps
`default_nettype none

module sync_reqack #(
  parameter bit EN_RZ_HS = 1'b0
) (
  input  logic clk_src_i,
  input  logic rst_src_ni,
  input  logic clk_dst_i,
  input  logic rst_dst_ni,
  input  logic src_req_i,
  output logic src_ack_o,
  output logic dst_req_o,
  input  logic dst_ack_i
);
  import cdc_bridge_pkg::*;

  if (EN_RZ_HS) begin : gen_rz
    ////////////////////////////////////////
    // Four-phase return-to-zero
    ////////////////////////////////////////
    sync_phase_e src_fsm_d, src_fsm_q;
    sync_phase_e dst_fsm_d, dst_fsm_q;
    logic        src_req_lvl;
    logic        dst_ack_lvl;
    logic        src_ack_sync;
    logic        dst_req_sync;

    // Request level into destination
    sync_2flop u_req_sync (
      .clk_i  (clk_dst_i),
      .rst_ni (rst_dst_ni),
      .d_i    (src_req_lvl),
      .q_o    (dst_req_sync)
    );

    // Acknowledge level back into source
    sync_2flop u_ack_sync (
      .clk_i  (clk_src_i),
      .rst_ni (rst_src_ni),
      .d_i    (dst_ack_lvl),
      .q_o    (src_ack_sync)
    );

    // Source side
    always_comb begin
      src_fsm_d   = src_fsm_q;
      src_req_lvl = 1'b0;
      src_ack_o   = 1'b0;
      unique case (src_fsm_q)
        PH_EVEN_LO: begin
          // Previous ack must have returned to zero
          if (!src_ack_sync && src_req_i) begin
            src_fsm_d = PH_ODD_HI;
          end
        end
        PH_ODD_HI: begin
          src_req_lvl = 1'b1;
          src_ack_o   = src_ack_sync;
          // Drop request once acknowledged
          if (!src_req_i || src_ack_sync) begin
            src_fsm_d = PH_EVEN_LO;
          end
        end
      endcase
    end

    // Destination side
    always_comb begin
      dst_fsm_d   = dst_fsm_q;
      dst_req_o   = 1'b0;
      dst_ack_lvl = 1'b0;
      unique case (dst_fsm_q)
        PH_EVEN_LO: begin
          dst_req_o = dst_req_sync;
          if (dst_req_sync && dst_ack_i) begin
            dst_fsm_d = PH_ODD_HI;
          end
        end
        PH_ODD_HI: begin
          dst_ack_lvl = 1'b1;
          // Hold ack until request returns to zero
          if (!dst_req_sync) begin
            dst_fsm_d = PH_EVEN_LO;
          end
        end
      endcase
    end

    always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
      if (!rst_src_ni) begin
        src_fsm_q <= PH_EVEN_LO;
      end else begin
        src_fsm_q <= src_fsm_d;
      end
    end

    always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
      if (!rst_dst_ni) begin
        dst_fsm_q <= PH_EVEN_LO;
      end else begin
        dst_fsm_q <= dst_fsm_d;
      end
    end

  end else begin : gen_nrz
    ////////////////////////////////////////
    // Two-phase non-return-to-zero
    ////////////////////////////////////////
    sync_phase_e src_fsm_d, src_fsm_q;
    sync_phase_e dst_fsm_d, dst_fsm_q;
    logic        src_req_d, src_req_q;
    logic        dst_ack_d, dst_ack_q;
    logic        src_ack_sync;
    logic        dst_req_sync;

    sync_2flop u_req_sync (
      .clk_i  (clk_dst_i),
      .rst_ni (rst_dst_ni),
      .d_i    (src_req_q),
      .q_o    (dst_req_sync)
    );

    sync_2flop u_ack_sync (
      .clk_i  (clk_src_i),
      .rst_ni (rst_src_ni),
      .d_i    (dst_ack_q),
      .q_o    (src_ack_sync)
    );

    // Source side, odd phase inverts both levels
    always_comb begin
      src_fsm_d = src_fsm_q;
      if (src_fsm_q == PH_ODD_HI) begin
        src_req_d = ~src_req_i;
        src_ack_o = ~src_ack_sync;
      end else begin
        src_req_d = src_req_i;
        src_ack_o = src_ack_sync;
      end
      // Every handshake toggles the phase
      if (src_req_i && src_ack_o) begin
        src_fsm_d = (src_fsm_q == PH_ODD_HI) ? PH_EVEN_LO : PH_ODD_HI;
      end
    end

    // Destination side, a level change is one request
    always_comb begin
      dst_fsm_d = dst_fsm_q;
      if (dst_fsm_q == PH_ODD_HI) begin
        dst_req_o = ~dst_req_sync;
        dst_ack_d = ~dst_ack_i;
      end else begin
        dst_req_o = dst_req_sync;
        dst_ack_d = dst_ack_i;
      end
      if (dst_req_o && dst_ack_i) begin
        dst_fsm_d = (dst_fsm_q == PH_ODD_HI) ? PH_EVEN_LO : PH_ODD_HI;
      end
    end

    always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
      if (!rst_src_ni) begin
        src_fsm_q <= PH_EVEN_LO;
        src_req_q <= 1'b0;
      end else begin
        src_fsm_q <= src_fsm_d;
        src_req_q <= src_req_d;
      end
    end

    always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
      if (!rst_dst_ni) begin
        dst_fsm_q <= PH_EVEN_LO;
        dst_ack_q <= 1'b0;
      end else begin
        dst_fsm_q <= dst_fsm_d;
        dst_ack_q <= dst_ack_d;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cdc_xfer_if.sv
// Crossing transaction bundle
// Handshake bits of both domains plus the quasi-static payload
// that crosses while a request is held
`timescale 1ns/1ps
`default_nettype none

interface cdc_xfer_if;
  import cdc_bridge_pkg::*;

  // Handshake, source and destination sides
  logic  src_req;
  logic  src_ack;
  logic  dst_req;
  logic  dst_ack;

  // Payload towards the bank
  logic  wr;
  addr_t addr;
  data_t wdata;
  // Read data back to the port
  data_t rdata;

  modport src_mp (output src_req, wr, addr, wdata, input src_ack, rdata);
  modport dst_mp (input dst_req, wr, addr, wdata, output dst_ack, rdata);
  modport sync_mp (input src_req, dst_ack, output src_ack, dst_req);

endinterface

`default_nettype wire

// File: hw/wb_src_port.sv
// Wishbone classic slave port, source domain
// Turns each single read or write cycle into one crossing
// transaction and returns ack with read data once it completes
`timescale 1ns/1ps
`default_nettype none

module wb_src_port (
  input  logic                  clk_src_i,
  input  logic                  rst_src_ni,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  cdc_bridge_pkg::addr_t wb_adr_i,
  input  cdc_bridge_pkg::data_t wb_dat_i,
  output cdc_bridge_pkg::data_t wb_dat_o,
  output logic                  wb_ack_o,
  cdc_xfer_if.src_mp            xfer
);
  import cdc_bridge_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_DONE
  } port_state_e;

  port_state_e state_q;

  // Payload, held stable while the request is out
  logic  wr_q;
  addr_t addr_q;
  data_t wdata_q;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: if (wb_cyc_i && wb_stb_i) state_q <= ST_BUSY;
        ST_BUSY: if (xfer.src_ack) state_q <= ST_DONE;
        // Ack cycle, then free for the next strobe
        ST_DONE: state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Capture the bus cycle on entry to busy
  always_ff @(posedge clk_src_i) begin
    if (state_q == ST_IDLE && wb_cyc_i && wb_stb_i) begin
      wr_q    <= wb_we_i;
      addr_q  <= wb_adr_i;
      wdata_q <= wb_dat_i;
    end
  end

  // Read data is stable when src_ack arrives
  always_ff @(posedge clk_src_i) begin
    if (state_q == ST_BUSY && xfer.src_ack) begin
      wb_dat_o <= xfer.rdata;
    end
  end

  assign xfer.src_req = (state_q == ST_BUSY);
  assign xfer.wr      = wr_q;
  assign xfer.addr    = addr_q;
  assign xfer.wdata   = wdata_q;
  assign wb_ack_o     = (state_q == ST_DONE);

endmodule

`default_nettype wire

// File: hw/dst_reg_bank.sv
// Destination-domain register bank
// Sixteen 32-bit registers, one access per crossing request,
// acknowledged in the same cycle the request shows up
`timescale 1ns/1ps
`default_nettype none

`include "cdc_bridge_cfg.svh"

module dst_reg_bank (
  input  logic       clk_dst_i,
  input  logic       rst_dst_ni,
  cdc_xfer_if.dst_mp xfer
);
  import cdc_bridge_pkg::*;

  data_t regs_q [`CDC_NUM_REGS];
  data_t rdata_q;

  // Bank is always ready
  assign xfer.dst_ack = xfer.dst_req;

  ////////////////////////////////////////
  // Register array
  ////////////////////////////////////////
  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      for (int i = 0; i < `CDC_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (xfer.dst_req && xfer.wr) begin
      regs_q[xfer.addr] <= xfer.wdata;
    end
  end

  // Return data, only changes at a handshake
  always_ff @(posedge clk_dst_i) begin
    if (xfer.dst_req) begin
      // Write echoes the new value
      if (xfer.wr) begin
        rdata_q <= xfer.wdata;
      end else begin
        rdata_q <= regs_q[xfer.addr];
      end
    end
  end

  assign xfer.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/cdc_reg_bridge.sv
// CDC register bridge, top level
// Wishbone classic slave in the source clock domain, register
// bank in the destination domain, joined by a REQ/ACK synchronizer
`timescale 1ns/1ps
`default_nettype none

`include "cdc_bridge_cfg.svh"

module cdc_reg_bridge #(
  parameter bit EN_RZ_HS = `CDC_EN_RZ_HS
) (
  input  logic                   clk_src_i,
  input  logic                   rst_src_ni,
  input  logic                   clk_dst_i,
  input  logic                   rst_dst_ni,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`CDC_ADDR_W-1:0] wb_adr_i,
  input  logic [`CDC_DATA_W-1:0] wb_dat_i,
  output logic [`CDC_DATA_W-1:0] wb_dat_o,
  output logic                   wb_ack_o
);

  cdc_xfer_if xfer ();

  // Source domain bus port
  wb_src_port u_src_port (
    .clk_src_i  (clk_src_i),
    .rst_src_ni (rst_src_ni),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .xfer       (xfer.src_mp)
  );

  // Handshake crossing, payload bypasses it
  sync_reqack #(
    .EN_RZ_HS (EN_RZ_HS)
  ) u_sync_reqack (
    .clk_src_i  (clk_src_i),
    .rst_src_ni (rst_src_ni),
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .src_req_i  (xfer.src_req),
    .src_ack_o  (xfer.src_ack),
    .dst_req_o  (xfer.dst_req),
    .dst_ack_i  (xfer.dst_ack)
  );

  // Destination domain registers
  dst_reg_bank u_reg_bank (
    .clk_dst_i  (clk_dst_i),
    .rst_dst_ni (rst_dst_ni),
    .xfer       (xfer.dst_mp)
  );

endmodule

`default_nettype wire

// File: tb/cdc_reg_bridge_properties.sv
// Handshake checks for the REQ/ACK synchronizer
// Bound into every sync_reqack instance, watches both the source
// and the destination side of the crossing
`timescale 1ns/1ps
`default_nettype none

module cdc_reg_bridge_properties (
  input logic clk_src_i,
  input logic rst_src_ni,
  input logic clk_dst_i,
  input logic rst_dst_ni,
  input logic src_req_i,
  input logic src_ack_i,
  input logic dst_req_i,
  input logic dst_ack_i
);

  ////////////////////////////////////////
  // Destination side
  ////////////////////////////////////////

  // Bank may only acknowledge a live request
  a_dst_ack_needs_req: assert property (
    @(posedge clk_dst_i) disable iff (!rst_dst_ni)
    dst_ack_i |-> dst_req_i
  ) else $error("dst_ack high while dst_req is low");

  // Request shows up for one cycle per transaction
  a_dst_req_single: assert property (
    @(posedge clk_dst_i) disable iff (!rst_dst_ni)
    dst_req_i |=> !dst_req_i
  ) else $error("dst_req high for two cycles in a row");

  ////////////////////////////////////////
  // Source side
  ////////////////////////////////////////

  // Request held until acknowledged
  a_src_req_held: assert property (
    @(posedge clk_src_i) disable iff (!rst_src_ni)
    (src_req_i && !src_ack_i) |=> src_req_i
  ) else $error("src_req dropped before src_ack");

  // One acknowledge pulse per transaction
  a_src_ack_single: assert property (
    @(posedge clk_src_i) disable iff (!rst_src_ni)
    src_ack_i |=> !src_ack_i
  ) else $error("src_ack high for two cycles in a row");

endmodule

bind sync_reqack cdc_reg_bridge_properties u_properties (
  .clk_src_i  (clk_src_i),
  .rst_src_ni (rst_src_ni),
  .clk_dst_i  (clk_dst_i),
  .rst_dst_ni (rst_dst_ni),
  .src_req_i  (src_req_i),
  .src_ack_i  (src_ack_o),
  .dst_req_i  (dst_req_o),
  .dst_ack_i  (dst_ack_i)
);

`default_nettype wire

// File: tb/cdc_reg_bridge_tb.sv
// Testbench for the CDC register bridge
// Drifting source and destination clocks, random Wishbone traffic
// from a fixed seed, every access checked against a register model
`timescale 1ns/1ps
`default_nettype none

`include "cdc_bridge_cfg.svh"

module cdc_reg_bridge_tb;
  import cdc_bridge_pkg::*;

  localparam int ACK_TIMEOUT = 60;
  localparam int SEED        = 70337;

  logic  clk_src;
  logic  clk_dst;
  logic  rst_src_n;
  logic  rst_dst_n;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  logic  wb_ack;
  addr_t wb_adr;
  data_t wb_dat_w;
  data_t wb_dat_r;

  // Expected register contents
  data_t model_q [`CDC_NUM_REGS];

  int err_count;
  int check_count;
  int ack_seen;
  int test_errs;
  int test_checks;

  cdc_reg_bridge dut (
    .clk_src_i  (clk_src),
    .rst_src_ni (rst_src_n),
    .clk_dst_i  (clk_dst),
    .rst_dst_ni (rst_dst_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack)
  );

  // 100 ns source, 130 ns destination
  always #50 clk_src = ~clk_src;
  always #65 clk_dst = ~clk_dst;

  // Count ack pulses, sampled mid-cycle
  always @(negedge clk_src) begin
    if (rst_src_n && wb_ack) begin
      ack_seen++;
    end
  end

  ////////////////////////////////////////
  // Bus helpers, called on a falling edge
  ////////////////////////////////////////

  // Both resets together, model back to zero
  task automatic apply_reset();
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    rst_src_n = 1'b0;
    rst_dst_n = 1'b0;
    repeat (10) @(negedge clk_src);
    rst_src_n = 1'b1;
    rst_dst_n = 1'b1;
    for (int i = 0; i < `CDC_NUM_REGS; i++) begin
      model_q[i] = '0;
    end
  endtask

  // One Wishbone cycle, hold keeps cyc/stb up for the next one
  task automatic bus_access(input logic we, input addr_t adr, input data_t dat,
                            input logic hold);
    int    cycles;
    logic  got_ack;
    data_t expected;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    cycles   = 0;
    got_ack  = 1'b0;
    while (!got_ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk_src);
      cycles++;
      got_ack = wb_ack;
    end
    if (!got_ack) begin
      $display("Timeout at %0t: no acknowledge came for register %0d within %0d cycles",
               $time, adr, ACK_TIMEOUT);
      err_count++;
    end else begin
      // Write echoes the new value, read returns the stored one
      expected = we ? dat : model_q[adr];
      if (we) begin
        model_q[adr] = dat;
      end
      check_count++;
      if (wb_dat_r !== expected) begin
        $display("Error at %0t: %s register %0d expected 0x%08h, got 0x%08h",
                 $time, we ? "write" : "read", adr, expected, wb_dat_r);
        err_count++;
      end
    end
    if (!hold) begin
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
    end
  endtask

  task automatic random_access(input logic hold);
    logic  w;
    addr_t a;
    data_t d;
    w = 1'($urandom_range(0, 1));
    a = addr_t'($urandom_range(0, `CDC_NUM_REGS - 1));
    d = $urandom;
    bus_access(w, a, d, hold);
  endtask

  task automatic start_test();
    test_errs   = err_count;
    test_checks = check_count;
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished: %0d checks, %0d errors",
             name, check_count - test_checks, err_count - test_errs);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    int seed_val;
    int acks_before;
    seed_val    = $urandom(SEED);
    clk_src     = 1'b0;
    clk_dst     = 1'b0;
    rst_src_n   = 1'b0;
    rst_dst_n   = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    err_count   = 0;
    check_count = 0;
    ack_seen    = 0;
    apply_reset();

    // Quiet bus after reset, all registers zero
    start_test();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_src);
      check_count++;
      if (wb_ack !== 1'b0) begin
        $display("Error at %0t: wb_ack_o high after reset with no bus cycle", $time);
        err_count++;
      end
    end
    for (int i = 0; i < `CDC_NUM_REGS; i++) begin
      bus_access(1'b0, addr_t'(i), '0, 1'b0);
    end
    end_test("1 reset state");

    // Fill every register, then read all back
    start_test();
    for (int i = 0; i < `CDC_NUM_REGS; i++) begin
      bus_access(1'b1, addr_t'(i), $urandom, 1'b0);
    end
    for (int i = 0; i < `CDC_NUM_REGS; i++) begin
      bus_access(1'b0, addr_t'(i), '0, 1'b0);
    end
    end_test("2 write and read all");

    // Strobe stays high across eight transactions
    start_test();
    // Previous ack is counted on the edge just passed
    @(negedge clk_src);
    acks_before = ack_seen;
    for (int i = 0; i < 8; i++) begin
      random_access(i < 7);
    end
    @(negedge clk_src);
    check_count++;
    if (ack_seen - acks_before != 8) begin
      $display("Error at %0t: back-to-back run expected 8 acks, saw %0d",
               $time, ack_seen - acks_before);
      err_count++;
    end
    end_test("3 back-to-back");

    // Long mix with idle gaps
    start_test();
    for (int i = 0; i < 200; i++) begin
      random_access(1'b0);
      repeat ($urandom_range(0, 4)) @(negedge clk_src);
    end
    end_test("4 random mix");

    // Reset in mid-run, then resume traffic
    start_test();
    for (int i = 0; i < `CDC_NUM_REGS; i++) begin
      bus_access(1'b1, addr_t'(i), $urandom | 32'h1, 1'b0);
    end
    apply_reset();
    for (int i = 0; i < `CDC_NUM_REGS; i++) begin
      bus_access(1'b0, addr_t'(i), '0, 1'b0);
    end
    for (int i = 0; i < 40; i++) begin
      random_access(1'b0);
    end
    end_test("5 mid-run reset");

    $display("Summary: 5 tests, %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cdc_reg_bridge.f
+incdir+hw
hw/cdc_bridge_pkg.sv
hw/sync_2flop.sv
hw/sync_reqack.sv
hw/cdc_xfer_if.sv
hw/wb_src_port.sv
hw/dst_reg_bank.sv
hw/cdc_reg_bridge.sv
tb/cdc_reg_bridge_properties.sv
tb/cdc_reg_bridge_tb.sv

// File: Bender.yml
package:
  name: cdc_reg_bridge

sources:
  - include_dirs:
      - hw
    files:
      - hw/cdc_bridge_pkg.sv
      - hw/sync_2flop.sv
      - hw/sync_reqack.sv
      - hw/cdc_xfer_if.sv
      - hw/wb_src_port.sv
      - hw/dst_reg_bank.sv
      - hw/cdc_reg_bridge.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/cdc_reg_bridge_properties.sv
      - tb/cdc_reg_bridge_tb.sv
